// File: hdl/super6502_pkg.sv
package super6502_pkg;

// ======================================================================
// Bus widths
// ======================================================================

typedef logic [15:0]    cpu_addr_t;     // CPU address
typedef logic [7:0]     cpu_data_t;     // CPU data byte and per-bit enable
typedef logic [8:0]     ram_addr_t;     // 512 byte RAM index
typedef logic [7:0]     rom_addr_t;     // 256 byte ROM index

// ======================================================================
// Memory map
// ======================================================================

localparam cpu_addr_t RAM_BASE = 16'h0000;
localparam cpu_addr_t RAM_LAST = 16'h01FF;
localparam cpu_addr_t ROM_BASE = 16'hFF00;
localparam cpu_addr_t ROM_LAST = 16'hFFFF;

localparam cpu_data_t OPEN_BUS_VALUE = 8'hFF;      // Pulled-up data lines

localparam string ROM_INIT_FILE = "boot_rom.mem";

// ======================================================================
// Reset timing and state encodings
// ======================================================================

localparam int RESET_HOLD_CYCLES = 16;              // CPU reset stretch

typedef enum logic [1:0] {
    REGION_RAM,
    REGION_ROM,
    REGION_OPEN
} bus_region_t;

typedef enum logic [1:0] {
    RST_ACTIVE,     // System reset asserted
    RST_HOLD,       // Counting out the stretch
    RST_RUN         // CPU released
} reset_state_t;

endpackage

// File: hdl/onchip_ram.sv
`timescale 1ns/100ps

module onchip_ram
    import super6502_pkg::*;
(
    input   logic               i_sysclk,
    input   ram_addr_t          i_ram_addr,
    input   logic               i_we,
    input   cpu_data_t          i_wdata,
    output  cpu_data_t          o_rdata
);

cpu_data_t mem [2**$bits(ram_addr_t)];

// Old data comes out on a same-cycle write to the same index
always_ff @(posedge i_sysclk) begin
    if (i_we) begin
        mem[i_ram_addr] <= i_wdata;
    end
    o_rdata <= mem[i_ram_addr];             // Registered read
end

endmodule

// File: hdl/boot_rom.sv
`timescale 1ns/100ps

module boot_rom
    import super6502_pkg::*;
(
    input   logic               i_sysclk,
    input   rom_addr_t          i_rom_addr,
    output  cpu_data_t          o_rdata
);

cpu_data_t mem [2**$bits(rom_addr_t)];

initial begin
    $readmemh(ROM_INIT_FILE, mem);          // Boot image
end

always_ff @(posedge i_sysclk) begin
    o_rdata <= mem[i_rom_addr];
end

endmodule

// File: hdl/reset_sequencer.sv
`timescale 1ns/100ps

module reset_sequencer
    import super6502_pkg::*;
(
    input   logic               i_sysclk,
    input   logic               i_reset,
    output  logic               o_cpu_reset,
    output  logic               o_cpu_held
);

reset_state_t state;
logic [$clog2(RESET_HOLD_CYCLES+1)-1:0] hold_cnt;

always_ff @(posedge i_sysclk) begin
    if (i_reset) begin
        state <= RST_ACTIVE;
        hold_cnt <= '0;
    end else begin
        case (state)
            RST_ACTIVE: begin
                state <= RST_HOLD;
                hold_cnt <= '0;
            end
            RST_HOLD: begin
                if (hold_cnt == RESET_HOLD_CYCLES - 1) begin
                    state <= RST_RUN;
                end
                hold_cnt <= hold_cnt + 1'b1;
            end
            default: begin
                state <= RST_RUN;               // Stay released
            end
        endcase
    end
end

assign o_cpu_reset = (state == RST_RUN);        // Active low toward the CPU
assign o_cpu_held  = (state != RST_RUN);

assert property (@(posedge i_sysclk) disable iff (i_reset)
    hold_cnt <= RESET_HOLD_CYCLES)
    else $error("Reset hold counter ran past its limit");

endmodule

// File: hdl/cpu_bus_bridge.sv
`timescale 1ns/100ps

module cpu_bus_bridge
    import super6502_pkg::*;
(
    input   logic               i_sysclk,
    input   logic               i_reset,
    input   logic               i_cpu_held,

    input   cpu_addr_t          i_cpu_addr,
    input   logic               i_cpu_rwb,
    input   cpu_data_t          i_cpu_data,

    input   cpu_data_t          i_ram_rdata,
    input   cpu_data_t          i_rom_rdata,

    output  ram_addr_t          o_ram_addr,
    output  logic               o_ram_we,
    output  cpu_data_t          o_ram_wdata,
    output  rom_addr_t          o_rom_addr,

    output  cpu_data_t          o_cpu_data,
    output  cpu_data_t          o_cpu_data_oe
);

// ======================================================================
// Address decode
// ======================================================================

bus_region_t region;

always_comb begin
    if (i_cpu_addr >= RAM_BASE && i_cpu_addr <= RAM_LAST) begin
        region = REGION_RAM;
    end else if (i_cpu_addr >= ROM_BASE && i_cpu_addr <= ROM_LAST) begin
        region = REGION_ROM;
    end else begin
        region = REGION_OPEN;                   // Unmapped, reads float high
    end
end

// Both memories see the address in the same cycle
assign o_ram_addr  = i_cpu_addr[$bits(ram_addr_t)-1:0];
assign o_rom_addr  = i_cpu_addr[$bits(rom_addr_t)-1:0];
assign o_ram_wdata = i_cpu_data;

// Only an unheld write into RAM lands
assign o_ram_we = ~i_cpu_rwb & ~i_cpu_held & (region == REGION_RAM);

// ======================================================================
// Data phase
// ======================================================================

bus_region_t region_q;
logic        read_q;

always_ff @(posedge i_sysclk) begin
    if (i_reset) begin
        region_q <= REGION_OPEN;
        read_q <= 1'b0;
    end else begin
        region_q <= region;
        read_q <= i_cpu_rwb & ~i_cpu_held;      // Drive only for a live read
    end
end

always_comb begin
    case (region_q)
        REGION_RAM: o_cpu_data = i_ram_rdata;
        REGION_ROM: o_cpu_data = i_rom_rdata;
        default:    o_cpu_data = OPEN_BUS_VALUE;
    endcase
end

assign o_cpu_data_oe = {$bits(cpu_data_t){read_q}};

// ======================================================================
// Checks
// ======================================================================

assert property (@(posedge i_sysclk) disable iff (i_reset)
    o_ram_we |-> !i_cpu_held)
    else $error("RAM write while the CPU is held in reset");

assert property (@(posedge i_sysclk) disable iff (i_reset)
    o_ram_we |-> (i_cpu_addr <= RAM_LAST))
    else $error("RAM write enable outside the RAM window");

endmodule

// File: hdl/super6502_core.sv
`timescale 1ns/100ps

module super6502_core
    import super6502_pkg::*;
(
    input   logic               i_sysclk,
    input   logic               i_reset,

    input   cpu_addr_t          i_cpu_addr,
    input   logic               i_cpu_rwb,          // 1 = read
    input   cpu_data_t          i_cpu_data,
    output  cpu_data_t          o_cpu_data,
    output  cpu_data_t          o_cpu_data_oe,
    output  logic               o_cpu_reset         // Active low
);

logic       cpu_held;

ram_addr_t  ram_addr;
logic       ram_we;
cpu_data_t  ram_wdata;
cpu_data_t  ram_rdata;

rom_addr_t  rom_addr;
cpu_data_t  rom_rdata;

reset_sequencer u_reset_sequencer (
    .i_sysclk       (i_sysclk),
    .i_reset        (i_reset),
    .o_cpu_reset    (o_cpu_reset),
    .o_cpu_held     (cpu_held)
);

cpu_bus_bridge u_cpu_bus_bridge (
    .i_sysclk       (i_sysclk),
    .i_reset        (i_reset),
    .i_cpu_held     (cpu_held),

    .i_cpu_addr     (i_cpu_addr),
    .i_cpu_rwb      (i_cpu_rwb),
    .i_cpu_data     (i_cpu_data),

    .i_ram_rdata    (ram_rdata),
    .i_rom_rdata    (rom_rdata),

    .o_ram_addr     (ram_addr),
    .o_ram_we       (ram_we),
    .o_ram_wdata    (ram_wdata),
    .o_rom_addr     (rom_addr),

    .o_cpu_data     (o_cpu_data),
    .o_cpu_data_oe  (o_cpu_data_oe)
);

onchip_ram u_ram (
    .i_sysclk       (i_sysclk),
    .i_ram_addr     (ram_addr),
    .i_we           (ram_we),
    .i_wdata        (ram_wdata),
    .o_rdata        (ram_rdata)
);

boot_rom u_rom (
    .i_sysclk       (i_sysclk),
    .i_rom_addr     (rom_addr),
    .o_rdata        (rom_rdata)
);

endmodule

// File: bench/tb_super6502.sv
`timescale 1ns/100ps

module tb_super6502
    import super6502_pkg::*;
();

// ======================================================================
// Run length
// ======================================================================

localparam int CLK_PERIOD    = 10;
localparam int RESET_CYCLES  = 3;
localparam int N_RAM         = 64;          // Random RAM writes
localparam int N_ROM         = 32;
localparam int N_OPEN        = 32;
localparam int N_ALIAS       = 16;          // Open writes aliasing RAM indices
localparam int N_MIX         = 24;
localparam int N_HELD_WRITES = 8;

localparam cpu_addr_t IDLE_ADDR = 16'h8000;  // Open region

localparam int T_RESET = RESET_CYCLES + 1;
localparam int TOTAL_CYCLES = (T_RESET + RESET_HOLD_CYCLES + 1)   // Reset stretch
                            + (2 * N_RAM)
                            + (N_ROM + 2)
                            + (N_OPEN + 2 * N_ALIAS)
                            + N_MIX
                            + (T_RESET + RESET_HOLD_CYCLES + 1 + N_RAM)
                            + 1;
localparam int WATCHDOG_NS = 2 * TOTAL_CYCLES * CLK_PERIOD;

// ======================================================================
// DUT and clock
// ======================================================================

logic       sysclk;
logic       reset;
cpu_addr_t  cpu_addr;
logic       cpu_rwb;
cpu_data_t  cpu_wdata;
cpu_data_t  cpu_rdata;
cpu_data_t  cpu_data_oe;
logic       cpu_reset_n;

super6502_core u_dut (
    .i_sysclk       (sysclk),
    .i_reset        (reset),
    .i_cpu_addr     (cpu_addr),
    .i_cpu_rwb      (cpu_rwb),
    .i_cpu_data     (cpu_wdata),
    .o_cpu_data     (cpu_rdata),
    .o_cpu_data_oe  (cpu_data_oe),
    .o_cpu_reset    (cpu_reset_n)
);

always #5 sysclk = ~sysclk;

// ======================================================================
// Reference models
// ======================================================================

cpu_data_t      rom_image [2**$bits(rom_addr_t)];
cpu_data_t      ram_model [2**$bits(ram_addr_t)];
cpu_addr_t      ram_written [$];               // RAM addresses holding known data
int             low_edges = 0;                  // Edges seen with system reset low
logic [31:0]    lfsr_state = 32'hfe237a5c;

// Access waiting for its data phase
logic           pend_valid = 1'b0;
cpu_addr_t      pend_addr;
cpu_data_t      pend_data;
cpu_data_t      pend_oe;

// CPU reset is released once the stretch has run out
always @(posedge sysclk) begin
    if (reset) begin
        low_edges <= 0;
    end else if (low_edges <= RESET_HOLD_CYCLES) begin
        low_edges <= low_edges + 1;
    end
end

function automatic logic cpu_held();
    return (low_edges <= RESET_HOLD_CYCLES);
endfunction

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value = {value[30:0], lfsr_state[0]};
    end
    return value;
endfunction

function automatic ram_addr_t ram_index(input cpu_addr_t a);
    return ram_addr_t'(a - RAM_BASE);
endfunction

function automatic rom_addr_t rom_index(input cpu_addr_t a);
    return rom_addr_t'(a - ROM_BASE);
endfunction

function automatic bus_region_t region_of(input cpu_addr_t a);
    if (a >= RAM_BASE && a <= RAM_LAST) begin
        return REGION_RAM;
    end
    if (a >= ROM_BASE && a <= ROM_LAST) begin
        return REGION_ROM;
    end
    return REGION_OPEN;
endfunction

function automatic cpu_data_t expected_read(input cpu_addr_t a);
    case (region_of(a))
        REGION_RAM: return ram_model[ram_index(a)];
        REGION_ROM: return rom_image[rom_index(a)];
        default:    return OPEN_BUS_VALUE;
    endcase
endfunction

function automatic cpu_addr_t rand_ram_addr();
    return cpu_addr_t'(RAM_BASE + take_bits($bits(ram_addr_t)));
endfunction

function automatic cpu_addr_t rand_rom_addr();
    return cpu_addr_t'(ROM_BASE + take_bits($bits(rom_addr_t)));
endfunction

function automatic cpu_addr_t rand_open_addr();
    int span;
    span = ROM_BASE - (RAM_LAST + 1);
    return cpu_addr_t'(RAM_LAST + 1 + (take_bits(16) % span));
endfunction

function automatic cpu_addr_t pick_written();
    return ram_written[take_bits(16) % ram_written.size()];
endfunction

// ======================================================================
// Checks
// ======================================================================

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
endtask

task automatic check_data(input cpu_addr_t a, input cpu_data_t exp, input cpu_data_t act);
    if (act !== exp) begin
        abort_run($sformatf("Fail o_cpu_data at address %h: expected %h, got %h", a, exp, act));
    end
endtask

task automatic check_oe(input cpu_data_t exp, input cpu_data_t act);
    if (act !== exp) begin
        abort_run($sformatf("Fail o_cpu_data_oe: expected %h, got %h", exp, act));
    end
endtask

task automatic check_reset(input logic exp, input logic act);
    if (act !== exp) begin
        abort_run($sformatf("Fail o_cpu_reset: expected %h, got %h", exp, act));
    end
endtask

task automatic check_rom_image();
    foreach (rom_image[i]) begin
        if ($isunknown(rom_image[i])) begin
            abort_run($sformatf("Boot image %s is missing or short at entry %0d",
                                ROM_INIT_FILE, i));
        end
    end
endtask

// ======================================================================
// Bus driver
// ======================================================================

// Presents one access and checks the data phase of the one before it
task automatic bus_cycle(input cpu_addr_t a, input logic rwb, input cpu_data_t wdata);
    logic held;
    @(posedge sysclk);
    cpu_addr  <= a;
    cpu_rwb   <= rwb;
    cpu_wdata <= wdata;
    @(negedge sysclk);
    check_reset(!cpu_held(), cpu_reset_n);
    if (pend_valid) begin
        check_oe(pend_oe, cpu_data_oe);
        if (pend_oe == '1) begin
            check_data(pend_addr, pend_data, cpu_rdata);
        end
    end
    held = cpu_held();                           // Status at the sampling edge
    pend_valid = 1'b1;
    pend_addr = a;
    if (rwb && !held) begin
        pend_oe = '1;
        pend_data = expected_read(a);
    end else begin
        pend_oe = '0;
        pend_data = OPEN_BUS_VALUE;
    end
    if (!rwb && !held && region_of(a) == REGION_RAM) begin
        ram_model[ram_index(a)] = wdata;
    end
endtask

task automatic apply_reset();
    @(posedge sysclk);
    reset <= 1'b1;
    cpu_addr <= IDLE_ADDR;
    cpu_rwb <= 1'b1;
    pend_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge sysclk);
    reset <= 1'b0;
    @(negedge sysclk);
    check_reset(1'b0, cpu_reset_n);
    check_oe('0, cpu_data_oe);
    check_data(IDLE_ADDR, OPEN_BUS_VALUE, cpu_rdata);
endtask

// ======================================================================
// Tests
// ======================================================================

task automatic test_reset_stretch();
    apply_reset();
    for (int k = 1; k <= RESET_HOLD_CYCLES + 1; k++) begin
        bus_cycle(IDLE_ADDR, 1'b1, '0);
        check_reset(logic'(k > RESET_HOLD_CYCLES), cpu_reset_n);
        check_oe('0, cpu_data_oe);
    end
endtask

task automatic test_ram_readback();
    cpu_addr_t a;
    for (int i = 0; i < N_RAM; i++) begin
        a = rand_ram_addr();
        bus_cycle(a, 1'b0, cpu_data_t'(take_bits(8)));
        ram_written.push_back(a);
    end
    for (int i = 0; i < N_RAM; i++) begin
        bus_cycle(ram_written[i], 1'b1, '0);     // Back to back
    end
endtask

task automatic test_rom_reads();
    cpu_addr_t a;
    for (int i = 0; i < N_ROM; i++) begin
        bus_cycle(rand_rom_addr(), 1'b1, '0);
    end
    a = rand_rom_addr();
    bus_cycle(a, 1'b0, ~rom_image[rom_index(a)]);
    bus_cycle(a, 1'b1, '0);
endtask

task automatic test_open_region();
    cpu_addr_t  a;
    logic [6:0] hi;
    for (int i = 0; i < N_OPEN; i++) begin
        bus_cycle(rand_open_addr(), 1'b1, '0);
    end
    // Upper bits 1..126 keep the alias inside 0200-FDFF
    for (int i = 0; i < N_ALIAS; i++) begin
        hi = 7'(1 + take_bits(7) % 126);
        a = {hi, ram_index(ram_written[i])};
        bus_cycle(a, 1'b0, ~ram_model[ram_index(ram_written[i])]);
    end
    for (int i = 0; i < N_ALIAS; i++) begin
        bus_cycle(ram_written[i], 1'b1, '0);
    end
endtask

task automatic test_oe_timing();
    logic      rwb;
    cpu_addr_t a;
    for (int i = 0; i < N_MIX; i++) begin
        if (i < 3) begin
            rwb = (i != 1);                      // Read, write, read to start
        end else begin
            rwb = take_bits(1);
        end
        if (rwb) begin
            case (take_bits(2))
                0, 1:    a = pick_written();
                2:       a = rand_rom_addr();
                default: a = rand_open_addr();
            endcase
            bus_cycle(a, 1'b1, '0);
        end else begin
            a = rand_ram_addr();
            bus_cycle(a, 1'b0, cpu_data_t'(take_bits(8)));
            ram_written.push_back(a);
        end
    end
endtask

task automatic test_reset_writes();
    cpu_addr_t a;
    apply_reset();
    for (int i = 0; i < N_HELD_WRITES; i++) begin
        a = ram_written[i];
        bus_cycle(a, 1'b0, ~ram_model[ram_index(a)]);
        if (!cpu_held()) begin
            abort_run("A RAM write in the reset test came after the CPU reset was released");
        end
    end
    while (cpu_held()) begin
        bus_cycle(IDLE_ADDR, 1'b1, '0);
    end
    for (int i = 0; i < N_RAM; i++) begin
        bus_cycle(ram_written[i], 1'b1, '0);
    end
endtask

// ======================================================================
// Sequence and watchdog
// ======================================================================

initial begin
    sysclk = 1'b0;
    reset = 1'b1;
    cpu_addr = IDLE_ADDR;
    cpu_rwb = 1'b1;
    cpu_wdata = '0;
    $readmemh(ROM_INIT_FILE, rom_image);
    check_rom_image();

    test_reset_stretch();
    test_ram_readback();
    test_rom_reads();
    test_open_region();
    test_oe_timing();
    test_reset_writes();
    bus_cycle(IDLE_ADDR, 1'b1, '0);              // Drains the last data phase

    $display("Test OK");
    $finish;
end

initial begin
    #(WATCHDOG_NS);
    abort_run("Timeout: the tests did not finish in the expected time");
end

endmodule

// File: boot_rom.mem
// Boot image, 16 bytes per line, first line at FF00 and last line at FFF0
A2 FF 9A D8 A9 00 A2 00 9D 00 00 9D 00 01 E8 D0
F7 A9 20 85 00 A9 FF 85 01 A0 00 B1 00 F0 06 20
80 FF C8 D0 F6 4C 25 FF 53 55 50 45 52 36 35 30
32 20 42 4F 4F 54 0D 0A 00 EA EA EA EA EA EA EA
00 01 02 04 08 10 20 40 80 1B 36 6C D8 AB 4D 9A
2F 5E BC 63 C6 97 35 6A D4 B3 7D FA EF C5 91 39
72 E4 D3 BD 61 C2 9F 25 4A 94 33 66 CC 83 1D 3A
74 E8 CB 8D 01 02 04 08 10 20 40 80 1B 36 6C D8
48 8A 48 AD 00 02 29 01 F0 F9 68 AA 68 8D 01 02
60 48 8A 48 98 48 BA BD 04 01 29 10 D0 02 68 A8
68 AA 68 40 3C 5A 96 C3 0F F0 A5 5A 69 96 E1 1E
10 32 54 76 98 BA DC FE 01 23 45 67 89 AB CD EF
7E 81 42 24 18 99 66 C3 3C E7 DB BD 5A A5 0F F0
11 22 33 44 55 66 77 88 99 AA BB CC DD EE 13 57
9B DF 02 46 8A CE 24 68 AC E0 35 79 BD F1 40 EA
EA EA EA EA EA EA EA EA EA EA 40 FF 00 FF 91 FF

// File: vlog.f
hdl/super6502_pkg.sv
hdl/onchip_ram.sv
hdl/boot_rom.sv
hdl/reset_sequencer.sv
hdl/cpu_bus_bridge.sv
hdl/super6502_core.sv
bench/tb_super6502.sv

// File: Bender.yml
package:
  name: super6502_core

sources:
  - files:
      - hdl/super6502_pkg.sv
      - hdl/onchip_ram.sv
      - hdl/boot_rom.sv
      - hdl/reset_sequencer.sv
      - hdl/cpu_bus_bridge.sv
      - hdl/super6502_core.sv

  - target: simulation
    files:
      - bench/tb_super6502.sv
